//--- common/rv_ctrl_pkg.sv
`default_nettype none

package rv_ctrl_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  typedef enum logic [1:0] {
    op_a_rs1, op_a_curr_pc, op_a_zero
  } op_a_sel_e;

  typedef enum logic [2:0] {
    op_b_rs2, op_b_imm_i, op_b_imm_u, op_b_imm_s, op_b_incr
  } op_b_sel_e;

  typedef enum logic {
    wb_ex_result, wb_lsu_data
  } wb_src_e;

  typedef enum logic [1:0] {
    jalr_none, jalr_rs1, jalr_mepc, jalr_mtvec
  } jalr_sel_e;

  typedef enum logic [2:0] {
    csr_none = 3'd0,
    csr_rw   = 3'd1,
    csr_rc   = 3'd2,
    csr_rs   = 3'd3,
    csr_int  = 3'd4 // bit 2 flags the interrupt.
  } csr_op_e;

  typedef struct packed {
    op_a_sel_e              op_a_sel;
    op_b_sel_e              op_b_sel;
    rv_isa_pkg::alu_op_e    alu_op;
    logic                   mem_req;
    logic                   mem_we;
    rv_isa_pkg::ldst_size_e mem_size;
    logic                   gpr_we;
    wb_src_e                wb_src;
    logic                   illegal;
    logic                   branch;
    logic                   jal;
    jalr_sel_e              jalr;
    logic                   int_rst;
    logic                   csr;
    csr_op_e                csr_op;
  } decode_ctrl_t;

endpackage

`default_nettype wire

//--- common/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  typedef enum logic [6:0] {
    opc_load     = 7'b0000011,
    opc_misc_mem = 7'b0001111,
    opc_op_imm   = 7'b0010011,
    opc_auipc    = 7'b0010111,
    opc_store    = 7'b0100011,
    opc_op       = 7'b0110011,
    opc_lui      = 7'b0110111,
    opc_branch   = 7'b1100011,
    opc_jalr     = 7'b1100111,
    opc_jal      = 7'b1101111,
    opc_system   = 7'b1110011
  } opcode_e;

  typedef enum logic [2:0] {
    ldst_b  = 3'b000,
    ldst_h  = 3'b001,
    ldst_w  = 3'b010,
    ldst_bu = 3'b100,
    ldst_hu = 3'b101
  } ldst_size_e;

  // {class, funct3}; class 00 plain, 01 alternate, 11 compare.
  typedef enum logic [4:0] {
    alu_add  = 5'b00_000, alu_sll  = 5'b00_001, alu_slt  = 5'b00_010,
    alu_sltu = 5'b00_011, alu_xor  = 5'b00_100, alu_srl  = 5'b00_101,
    alu_or   = 5'b00_110, alu_and  = 5'b00_111, alu_sub  = 5'b01_000,
    alu_sra  = 5'b01_101, alu_eq   = 5'b11_000, alu_ne   = 5'b11_001,
    alu_lt   = 5'b11_100, alu_ge   = 5'b11_101, alu_ltu  = 5'b11_110,
    alu_geu  = 5'b11_111
  } alu_op_e;

  localparam logic [6:0]  funct7_base = 7'b0000000;
  localparam logic [6:0]  funct7_alt  = 7'b0100000;
  localparam logic [11:0] mret_imm    = 12'b0011000_00010;

endpackage

`default_nettype wire

//--- decode/main_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module main_decoder (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic [31:0]               instr_i,
  input  logic                      lsu_stall_i,
  input  logic                      int_i,
  output rv_ctrl_pkg::decode_ctrl_t ctrl_o,
  output logic                      enpc_o
);
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       int_buf;
  logic       int_pulse;

  assign funct3    = instr_i[14:12];
  assign funct7    = instr_i[31:25];
  assign enpc_o    = ~lsu_stall_i;
  assign int_pulse = int_i & int_buf; // int_i just rose.

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      int_buf <= 1'b0;
    end else begin
      int_buf <= ~int_i;
    end
  end

  always_comb begin
    ctrl_o.op_a_sel = op_a_rs1;
    ctrl_o.op_b_sel = op_b_rs2;
    ctrl_o.alu_op   = alu_add;
    ctrl_o.mem_req  = 1'b0;
    ctrl_o.mem_we   = 1'b0;
    ctrl_o.mem_size = ldst_b;
    ctrl_o.gpr_we   = 1'b0;
    ctrl_o.wb_src   = wb_ex_result;
    ctrl_o.illegal  = 1'b0;
    ctrl_o.branch   = 1'b0;
    ctrl_o.jal      = 1'b0;
    ctrl_o.jalr     = jalr_none;
    ctrl_o.int_rst  = 1'b0;
    ctrl_o.csr      = 1'b0;
    ctrl_o.csr_op   = csr_none;

    case (instr_i[6:0])
      opc_load: begin
        ctrl_o.op_b_sel = op_b_imm_i;
        ctrl_o.mem_req  = 1'b1;
        ctrl_o.mem_size = ldst_size_e'(funct3);
        ctrl_o.gpr_we   = 1'b1;
        ctrl_o.wb_src   = wb_lsu_data;
        if (!(funct3 inside {ldst_b, ldst_h, ldst_w, ldst_bu, ldst_hu})) begin
          ctrl_o.illegal  = 1'b1;
          ctrl_o.mem_size = ldst_b;
          ctrl_o.mem_req  = 1'b0;
        end
      end
      opc_misc_mem: begin
      end // fence is a nop here.
      opc_op_imm: begin
        ctrl_o.op_b_sel = op_b_imm_i;
        ctrl_o.gpr_we   = 1'b1;
        ctrl_o.alu_op   = alu_op_e'({2'b00, funct3});
        if (funct3 == 3'b101 && funct7 == funct7_alt) begin
          ctrl_o.alu_op = alu_sra;
        end
        if (funct3 == 3'b001) begin
          ctrl_o.illegal = (funct7 != funct7_base);
        end else if (funct3 == 3'b101) begin
          ctrl_o.illegal = (funct7 != funct7_base) && (funct7 != funct7_alt);
        end
      end
      opc_auipc: begin
        ctrl_o.op_a_sel = op_a_curr_pc;
        ctrl_o.op_b_sel = op_b_imm_u;
        ctrl_o.gpr_we   = 1'b1;
      end
      opc_store: begin
        ctrl_o.op_b_sel = op_b_imm_s;
        ctrl_o.mem_req  = 1'b1;
        ctrl_o.mem_we   = 1'b1;
        ctrl_o.mem_size = ldst_size_e'(funct3);
        if (!(funct3 inside {ldst_b, ldst_h, ldst_w})) begin
          ctrl_o.illegal  = 1'b1;
          ctrl_o.mem_size = ldst_b;
          ctrl_o.mem_req  = 1'b0;
          ctrl_o.mem_we   = 1'b0;
        end
      end
      opc_op: begin
        ctrl_o.gpr_we = 1'b1;
        ctrl_o.alu_op = alu_op_e'({2'b00, funct3});
        if (funct7 == funct7_alt) begin
          ctrl_o.alu_op  = alu_op_e'({2'b01, funct3});
          ctrl_o.illegal = !(funct3 inside {3'b000, 3'b101}); // sub and sra only.
        end else begin
          ctrl_o.illegal = (funct7 != funct7_base);
        end
      end
      opc_lui: begin
        ctrl_o.op_a_sel = op_a_zero;
        ctrl_o.op_b_sel = op_b_imm_u;
        ctrl_o.gpr_we   = 1'b1;
      end
      opc_branch: begin
        ctrl_o.alu_op = alu_op_e'({2'b11, funct3});
        ctrl_o.branch = 1'b1;
        if (funct3 inside {3'b010, 3'b011}) begin
          ctrl_o.illegal = 1'b1;
          ctrl_o.alu_op  = alu_eq;
        end
      end
      opc_jalr, opc_jal: begin
        ctrl_o.op_a_sel = op_a_curr_pc; // link value pc + 4.
        ctrl_o.op_b_sel = op_b_incr;
        ctrl_o.gpr_we   = 1'b1;
        if (instr_i[3]) begin
          ctrl_o.jal = 1'b1;
        end else begin
          ctrl_o.jalr    = jalr_rs1;
          ctrl_o.illegal = (funct3 != 3'b000);
        end
      end
      opc_system: begin
        ctrl_o.op_b_sel = op_b_incr;
        case (funct3)
          3'b000: begin
            if (instr_i[31:20] == mret_imm) begin
              ctrl_o.jalr    = jalr_mepc;
              ctrl_o.int_rst = 1'b1;
            end else begin
              ctrl_o.illegal = 1'b1;
            end
          end
          3'b001: begin
            ctrl_o.csr    = 1'b1;
            ctrl_o.csr_op = csr_rw;
          end
          3'b010: begin
            ctrl_o.csr    = 1'b1;
            ctrl_o.csr_op = csr_rs;
          end
          3'b011: begin
            ctrl_o.csr    = 1'b1;
            ctrl_o.csr_op = csr_rc;
          end
          default: ctrl_o.illegal = 1'b1;
        endcase
      end
      default: ctrl_o.illegal = 1'b1;
    endcase

    if (int_pulse) begin
      ctrl_o.jalr   = jalr_mtvec;
      ctrl_o.csr_op = csr_op_e'(ctrl_o.csr_op | csr_int);
    end
    ctrl_o.gpr_we = ctrl_o.gpr_we & enpc_o; // no write while stalled.
  end

endmodule

`default_nettype wire

//--- logic/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
  input  rv_isa_pkg::alu_op_e           op_i,
  input  logic                          branch_i,
  input  logic [rv_ctrl_pkg::xlen-1:0] a_i,
  input  logic [rv_ctrl_pkg::xlen-1:0] b_i,
  output logic [rv_ctrl_pkg::xlen-1:0] result_o,
  output logic                          flag_o
);
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  logic [4:0] shamt;
  logic       lt;
  logic       ltu;
  logic       cmp;

  assign shamt = b_i[4:0];
  assign lt    = $signed(a_i) < $signed(b_i);
  assign ltu   = a_i < b_i;

  always_comb begin
    result_o = '0;
    case (op_i)
      alu_add:  result_o = a_i + b_i;
      alu_sub:  result_o = a_i - b_i;
      alu_sll:  result_o = a_i << shamt;
      alu_slt:  result_o = {{(xlen-1){1'b0}}, lt};
      alu_sltu: result_o = {{(xlen-1){1'b0}}, ltu};
      alu_xor:  result_o = a_i ^ b_i;
      alu_srl:  result_o = a_i >> shamt;
      alu_sra:  result_o = $signed(a_i) >>> shamt;
      alu_or:   result_o = a_i | b_i;
      alu_and:  result_o = a_i & b_i;
      default:  result_o = '0; // compares give zero.
    endcase
  end

  always_comb begin
    case (op_i)
      alu_eq:  cmp = (a_i == b_i);
      alu_ne:  cmp = (a_i != b_i);
      alu_lt:  cmp = lt;
      alu_ge:  cmp = ~lt;
      alu_ltu: cmp = ltu;
      alu_geu: cmp = ~ltu;
      default: cmp = 1'b0;
    endcase
  end

  assign flag_o = cmp & branch_i; // taken only for a branch.

endmodule

`default_nettype wire

//--- logic/operand_select.sv
`timescale 1ns/1ns
`default_nettype none

module operand_select (
  input  rv_ctrl_pkg::decode_ctrl_t     ctrl_i,
  input  logic [rv_ctrl_pkg::xlen-1:0] instr_i,
  input  logic [rv_ctrl_pkg::xlen-1:0] pc_i,
  input  logic [rv_ctrl_pkg::xlen-1:0] rs1_data_i,
  input  logic [rv_ctrl_pkg::xlen-1:0] rs2_data_i,
  output logic [rv_ctrl_pkg::xlen-1:0] op_a_o,
  output logic [rv_ctrl_pkg::xlen-1:0] op_b_o
);
  import rv_ctrl_pkg::*;

  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_u;

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_u = {instr_i[31:12], 12'b0};

  always_comb begin
    case (ctrl_i.op_a_sel)
      op_a_rs1:     op_a_o = rs1_data_i;
      op_a_curr_pc: op_a_o = pc_i;
      default:      op_a_o = '0;
    endcase
  end

  always_comb begin
    case (ctrl_i.op_b_sel)
      op_b_rs2:   op_b_o = rs2_data_i;
      op_b_imm_i: op_b_o = imm_i;
      op_b_imm_u: op_b_o = imm_u;
      op_b_imm_s: op_b_o = imm_s;
      op_b_incr:  op_b_o = xlen'(4); // next instruction.
      default:    op_b_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic [rv_ctrl_pkg::reg_addr_w-1:0] rs1_addr_i,
  input  logic [rv_ctrl_pkg::reg_addr_w-1:0] rs2_addr_i,
  output logic [rv_ctrl_pkg::xlen-1:0]       rs1_data_o,
  output logic [rv_ctrl_pkg::xlen-1:0]       rs2_data_o,
  input  logic                               we_i,
  input  rv_ctrl_pkg::wb_src_e               wb_src_i,
  input  logic [rv_ctrl_pkg::reg_addr_w-1:0] rd_addr_i,
  input  logic [rv_ctrl_pkg::xlen-1:0]       ex_result_i,
  input  logic [rv_ctrl_pkg::xlen-1:0]       lsu_data_i,
  output logic [rv_ctrl_pkg::xlen-1:0]       wb_data_o
);
  import rv_ctrl_pkg::*;

  logic [xlen-1:0] regs [2**reg_addr_w];

  assign wb_data_o  = (wb_src_i == wb_lsu_data) ? lsu_data_i : ex_result_i;
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      for (int i = 0; i < 2**reg_addr_w; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && rd_addr_i != '0) begin
      regs[rd_addr_i] <= wb_data_o;
    end
  end

endmodule

`default_nettype wire

//--- logic/rv_decode_exec.sv
`timescale 1ns/1ns
`default_nettype none

module rv_decode_exec (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic [rv_ctrl_pkg::xlen-1:0] instr_i,
  input  logic [rv_ctrl_pkg::xlen-1:0] pc_i,
  input  logic                          lsu_stall_i,
  input  logic                          int_i,
  input  logic [rv_ctrl_pkg::xlen-1:0] lsu_rdata_i,
  output rv_ctrl_pkg::decode_ctrl_t     ctrl_o,
  output logic [rv_ctrl_pkg::xlen-1:0] alu_result_o,
  output logic                          branch_taken_o,
  output logic [rv_ctrl_pkg::xlen-1:0] mem_addr_o,
  output logic [rv_ctrl_pkg::xlen-1:0] mem_wdata_o,
  output logic [rv_ctrl_pkg::xlen-1:0] wb_data_o,
  output logic                          wb_we_o,
  output logic                          enpc_o
);
  import rv_ctrl_pkg::*;

  decode_ctrl_t    ctrl;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;

  assign ctrl_o      = ctrl;
  assign wb_we_o     = ctrl.gpr_we;
  assign mem_addr_o  = alu_result_o; // rs1 + imm for loads and stores.
  assign mem_wdata_o = rs2_data;

  main_decoder main_decoder_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .instr_i     (instr_i),
    .lsu_stall_i (lsu_stall_i),
    .int_i       (int_i),
    .ctrl_o      (ctrl),
    .enpc_o      (enpc_o)
  );

  reg_file reg_file_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .rs1_addr_i  (instr_i[19:15]),
    .rs2_addr_i  (instr_i[24:20]),
    .rs1_data_o  (rs1_data),
    .rs2_data_o  (rs2_data),
    .we_i        (ctrl.gpr_we),
    .wb_src_i    (ctrl.wb_src),
    .rd_addr_i   (instr_i[11:7]),
    .ex_result_i (alu_result_o),
    .lsu_data_i  (lsu_rdata_i),
    .wb_data_o   (wb_data_o)
  );

  operand_select operand_select_i (
    .ctrl_i     (ctrl),
    .instr_i    (instr_i),
    .pc_i       (pc_i),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .op_a_o     (op_a),
    .op_b_o     (op_b)
  );

  alu alu_i (
    .op_i     (ctrl.alu_op),
    .branch_i (ctrl.branch),
    .a_i      (op_a),
    .b_i      (op_b),
    .result_o (alu_result_o),
    .flag_o   (branch_taken_o)
  );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sim.f --top-module tb_rv_decode_exec -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
grep -qF "*** PASSED ***" sim.log
echo "simulation passed"

//--- sim.f
common/rv_isa_pkg.sv
common/rv_ctrl_pkg.sv
decode/main_decoder.sv
logic/operand_select.sv
logic/reg_file.sv
logic/alu.sv
logic/rv_decode_exec.sv
test/exec_checker.sv
test/rv_decode_exec_properties.sv
test/tb_rv_decode_exec.sv

//--- test/exec_checker.sv
`timescale 1ns/1ns
`default_nettype none

module exec_checker (
  input  logic                      clk_i,
  input  logic                      valid_i,
  input  logic [159:0]              name_i,
  input  logic                      stall_i,
  input  logic [31:0]               exp_result_i,
  input  logic                      exp_branch_i,
  input  logic                      exp_illegal_i,
  input  logic                      exp_we_i,
  input  logic [31:0]               exp_wb_i,
  input  logic [2:0]                exp_size_i,
  input  logic [1:0]                exp_jalr_i,
  input  logic [2:0]                exp_csr_i,
  input  logic                      exp_irst_i,
  input  logic                      chk_wdata_i,
  input  logic [31:0]               exp_wdata_i,
  input  rv_ctrl_pkg::decode_ctrl_t ctrl_i,
  input  logic [31:0]               alu_result_i,
  input  logic                      branch_taken_i,
  input  logic [31:0]               mem_addr_i,
  input  logic [31:0]               mem_wdata_i,
  input  logic [31:0]               wb_data_i,
  input  logic                      wb_we_i,
  input  logic                      enpc_i,
  output int                        checks_o,
  output int                        errors_o
);
  string       field;
  logic [31:0] exp_v;
  logic [31:0] act_v;
  int          checks = 0;
  int          errors = 0;

  assign checks_o = checks;
  assign errors_o = errors;

  // keeps the first mismatch of a test.
  task automatic note(input string f, input logic [31:0] e, input logic [31:0] a);
    if (field == "" && e !== a) begin
      field = f;
      exp_v = e;
      act_v = a;
    end
  endtask

  always @(negedge clk_i) begin
    if (valid_i) begin
      field = "";
      note("alu_result", exp_result_i, alu_result_i);
      note("mem_addr", exp_result_i, mem_addr_i);
      if (chk_wdata_i) begin
        note("mem_wdata", exp_wdata_i, mem_wdata_i);
      end
      note("branch_taken", 32'(exp_branch_i), 32'(branch_taken_i));
      note("illegal", 32'(exp_illegal_i), 32'(ctrl_i.illegal));
      note("wb_we", 32'(exp_we_i), 32'(wb_we_i));
      note("wb_data", exp_wb_i, wb_data_i);
      note("enpc", 32'(!stall_i), 32'(enpc_i)); // pc held while stalled.
      note("mem_size", 32'(exp_size_i), 32'(ctrl_i.mem_size));
      note("jalr", 32'(exp_jalr_i), 32'(ctrl_i.jalr));
      note("csr_op", 32'(exp_csr_i), 32'(ctrl_i.csr_op));
      note("int_rst", 32'(exp_irst_i), 32'(ctrl_i.int_rst));
      checks = checks + 1;
      if (field != "") begin
        errors = errors + 1;
        $display("Fail %0s %0s: expected %h actual %h", name_i, field, exp_v, act_v);
      end else begin
        $display("ok   %0s", name_i);
      end
    end
  end

endmodule

`default_nettype wire

//--- test/rv_decode_exec_properties.sv
`timescale 1ns/1ns
`default_nettype none

module rv_decode_exec_properties (
  input logic                      clk_i,
  input logic                      rst_i,
  input logic                      lsu_stall_i,
  input logic                      wb_we_i,
  input rv_ctrl_pkg::decode_ctrl_t ctrl_i
);

  no_write_in_stall: assert property (@(posedge clk_i) disable iff (rst_i)
    lsu_stall_i |-> !wb_we_i) else $error("register write while stalled");

  int_single_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
    ctrl_i.csr_op[2] |=> !ctrl_i.csr_op[2]) else $error("interrupt flag held twice");

  no_req_on_illegal: assert property (@(posedge clk_i) disable iff (rst_i)
    ctrl_i.illegal |-> !ctrl_i.mem_req) else $error("memory request on illegal decode");

endmodule

bind rv_decode_exec rv_decode_exec_properties rv_decode_exec_properties_i (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .lsu_stall_i (lsu_stall_i),
  .wb_we_i     (wb_we_o),
  .ctrl_i      (ctrl_o)
);

`default_nettype wire

//--- test/tb_rv_decode_exec.sv
`timescale 1ns/1ns
`default_nettype none

module tb_rv_decode_exec;
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  typedef struct packed {
    logic [159:0] name;
    logic [31:0]  instr;
    logic [31:0]  pc;
    logic         stall;
    logic         irq;
    logic [31:0]  rdata;
    logic [31:0]  exp_res;
    logic         exp_br;
    logic         exp_ill;
    logic         exp_we;
    logic [31:0]  exp_wb;
    logic [2:0]   exp_size;
    logic [1:0]   exp_jalr;
    logic [2:0]   exp_csr;
    logic         exp_irst;
    logic         chk_wdata;
    logic [31:0]  exp_wdata;
  } test_t;

  logic         clk_i;
  logic         rst_i;
  logic [31:0]  instr_i;
  logic [31:0]  pc_i;
  logic         lsu_stall_i;
  logic         int_i;
  logic [31:0]  lsu_rdata_i;
  decode_ctrl_t ctrl;
  logic [31:0]  alu_result;
  logic         branch_taken;
  logic [31:0]  mem_addr;
  logic [31:0]  mem_wdata;
  logic [31:0]  wb_data;
  logic         wb_we;
  logic         enpc;
  logic         valid;
  test_t        cur;
  test_t        tests[$];
  test_t        t;
  int           checks;
  int           errors;
  int           cycles = 0;
  int           limit = 0;

  rv_decode_exec rv_decode_exec_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .instr_i        (instr_i),
    .pc_i           (pc_i),
    .lsu_stall_i    (lsu_stall_i),
    .int_i          (int_i),
    .lsu_rdata_i    (lsu_rdata_i),
    .ctrl_o         (ctrl),
    .alu_result_o   (alu_result),
    .branch_taken_o (branch_taken),
    .mem_addr_o     (mem_addr),
    .mem_wdata_o    (mem_wdata),
    .wb_data_o      (wb_data),
    .wb_we_o        (wb_we),
    .enpc_o         (enpc)
  );

  exec_checker exec_checker_i (
    .clk_i          (clk_i),
    .valid_i        (valid),
    .name_i         (cur.name),
    .stall_i        (cur.stall),
    .exp_result_i   (cur.exp_res),
    .exp_branch_i   (cur.exp_br),
    .exp_illegal_i  (cur.exp_ill),
    .exp_we_i       (cur.exp_we),
    .exp_wb_i       (cur.exp_wb),
    .exp_size_i     (cur.exp_size),
    .exp_jalr_i     (cur.exp_jalr),
    .exp_csr_i      (cur.exp_csr),
    .exp_irst_i     (cur.exp_irst),
    .chk_wdata_i    (cur.chk_wdata),
    .exp_wdata_i    (cur.exp_wdata),
    .ctrl_i         (ctrl),
    .alu_result_i   (alu_result),
    .branch_taken_i (branch_taken),
    .mem_addr_i     (mem_addr),
    .mem_wdata_i    (mem_wdata),
    .wb_data_i      (wb_data),
    .wb_we_i        (wb_we),
    .enpc_i         (enpc),
    .checks_o       (checks),
    .errors_o       (errors)
  );

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("*** FAILED ***");
      $finish;
    end
  end

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  // defaults describe a plain legal instruction at pc 0x100.
  function automatic test_t row(input logic [159:0] name, input logic [31:0] instr,
                                input logic [31:0] res, input logic we);
    test_t r;
    r = '0;
    r.name    = name;
    r.instr   = instr;
    r.pc      = 32'h100;
    r.exp_res = res;
    r.exp_we  = we;
    r.exp_wb  = res;
    return r;
  endfunction

  task automatic build_table();
    tests.push_back(row("addi x1,x0,-7", i_type(12'hFF9, 0, 0, 1, opc_op_imm), 32'hFFFFFFF9, 1));
    tests.push_back(row("addi x2,x0,100", i_type(12'd100, 0, 0, 2, opc_op_imm), 32'd100, 1));
    tests.push_back(row("add x3,x1,x2", r_type(7'h00, 2, 1, 0, 3, opc_op), 32'd93, 1));
    tests.push_back(row("sub x4,x2,x1", r_type(7'h20, 1, 2, 0, 4, opc_op), 32'd107, 1));
    tests.push_back(row("sra x5,x1,x2", r_type(7'h20, 2, 1, 5, 5, opc_op), 32'hFFFFFFFF, 1));
    tests.push_back(row("sltu x6,x2,x1", r_type(7'h00, 1, 2, 3, 6, opc_op), 32'd1, 1));
    tests.push_back(row("xor x7,x1,x2", r_type(7'h00, 2, 1, 4, 7, opc_op), 32'hFFFFFF9D, 1));
    tests.push_back(row("add x8,x3,x4", r_type(7'h00, 4, 3, 0, 8, opc_op), 32'd200, 1));
    tests.push_back(row("lui x9", {20'h12345, 5'd9, 7'b0110111}, 32'h12345000, 1));
    tests.push_back(row("auipc x10", {20'h00001, 5'd10, 7'b0010111}, 32'h1100, 1));
    tests.push_back(row("jal x11", {20'h0, 5'd11, 7'b1101111}, 32'h104, 1));
    t = row("jalr x12,0(x1)", i_type(0, 1, 0, 12, opc_jalr), 32'h104, 1);
    t.exp_jalr = 2'd1;
    tests.push_back(t);
    t = row("jalr f3=1 illegal", i_type(0, 1, 1, 12, opc_jalr), 32'h104, 1);
    t.exp_jalr = 2'd1;
    t.exp_ill  = 1'b1;
    tests.push_back(t);
    t = row("lw x13,8(x2)", i_type(12'd8, 2, 2, 13, opc_load), 32'd108, 1);
    t.rdata    = 32'hCAFEF00D;
    t.exp_wb   = 32'hCAFEF00D;
    t.exp_size = 3'd2;
    tests.push_back(t);
    t = row("lhu x14,-4(x2)", i_type(12'hFFC, 2, 5, 14, opc_load), 32'd96, 1);
    t.rdata    = 32'h0000BEEF;
    t.exp_wb   = 32'h0000BEEF;
    t.exp_size = 3'd5;
    tests.push_back(t);
    t = row("load f3=3 illegal", i_type(0, 2, 3, 15, opc_load), 32'd100, 1);
    t.exp_wb  = 32'd0; // lsu data is selected and the port is zero.
    t.exp_ill = 1'b1;
    tests.push_back(t);
    t = row("sw x13,12(x2)", s_type(12'd12, 13, 2, 2), 32'd112, 0);
    t.exp_size  = 3'd2;
    t.chk_wdata = 1'b1;
    t.exp_wdata = 32'hCAFEF00D;
    tests.push_back(t);
    t = row("store f3=4 illegal", s_type(0, 13, 2, 4), 32'd100, 0);
    t.exp_ill   = 1'b1;
    t.chk_wdata = 1'b1;
    t.exp_wdata = 32'hCAFEF00D;
    tests.push_back(t);
    t = row("sb x0,-16(x2)", s_type(12'hFF0, 0, 2, 0), 32'd84, 0);
    t.chk_wdata = 1'b1;
    tests.push_back(t);
    t = row("beq taken", r_type(0, 1, 1, 0, 0, opc_branch), 0, 0);
    t.exp_br = 1'b1;
    tests.push_back(t);
    tests.push_back(row("beq not taken", r_type(0, 2, 1, 0, 0, opc_branch), 0, 0));
    t = row("bne taken", r_type(0, 2, 1, 1, 0, opc_branch), 0, 0);
    t.exp_br = 1'b1;
    tests.push_back(t);
    t = row("blt taken", r_type(0, 2, 1, 4, 0, opc_branch), 0, 0);
    t.exp_br = 1'b1;
    tests.push_back(t);
    tests.push_back(row("blt not taken", r_type(0, 1, 2, 4, 0, opc_branch), 0, 0));
    t = row("bgeu taken", r_type(0, 2, 1, 7, 0, opc_branch), 0, 0);
    t.exp_br = 1'b1;
    tests.push_back(t);
    tests.push_back(row("bgeu not taken", r_type(0, 1, 2, 7, 0, opc_branch), 0, 0));
    t = row("branch f3=2 illegal", r_type(0, 2, 1, 2, 0, opc_branch), 0, 0);
    t.exp_ill = 1'b1;
    tests.push_back(t);
    t = row("branch f3=3 illegal", r_type(0, 2, 1, 3, 0, opc_branch), 0, 0);
    t.exp_ill = 1'b1;
    tests.push_back(t);
    t = row("mret", i_type(12'h302, 0, 0, 0, opc_system), 32'd4, 0);
    t.exp_jalr = 2'd2;
    t.exp_irst = 1'b1;
    tests.push_back(t);
    t = row("csrrw", i_type(12'h300, 0, 1, 5, opc_system), 32'd4, 0);
    t.exp_csr = 3'd1;
    tests.push_back(t);
    t = row("csrrs", i_type(12'h300, 0, 2, 5, opc_system), 32'd4, 0);
    t.exp_csr = 3'd3;
    tests.push_back(t);
    t = row("csrrc", i_type(12'h300, 0, 3, 5, opc_system), 32'd4, 0);
    t.exp_csr = 3'd2;
    tests.push_back(t);
    t = row("system f3=4 illegal", i_type(12'h300, 0, 4, 5, opc_system), 32'd4, 0);
    t.exp_ill = 1'b1;
    tests.push_back(t);
    t = row("ecall illegal", i_type(0, 0, 0, 0, opc_system), 32'd4, 0);
    t.exp_ill = 1'b1;
    tests.push_back(t);
    t = row("unknown opcode", 32'h0000000B, 0, 0);
    t.exp_ill = 1'b1;
    tests.push_back(t);
    t = row("low bits 01", i_type(0, 0, 0, 1, 7'b0010001), 0, 0);
    t.exp_ill = 1'b1;
    tests.push_back(t);
    t = row("addi stalled", i_type(12'd55, 0, 0, 1, opc_op_imm), 32'd55, 0);
    t.stall = 1'b1;
    tests.push_back(t);
    tests.push_back(row("x1 unchanged", i_type(0, 1, 0, 16, opc_op_imm), 32'hFFFFFFF9, 1));
    t = row("int rise", i_type(0, 0, 0, 0, opc_op_imm), 0, 1);
    t.irq      = 1'b1;
    t.exp_jalr = 2'd3;
    t.exp_csr  = 3'd4;
    tests.push_back(t);
    t = row("int held", i_type(0, 0, 0, 0, opc_op_imm), 0, 1);
    t.irq = 1'b1;
    tests.push_back(t);
    tests.push_back(row("int low", i_type(0, 0, 0, 0, opc_op_imm), 0, 1));
  endtask

  initial begin
    clk_i       = 1'b0;
    rst_i       = 1'b1;
    instr_i     = '0;
    pc_i        = '0;
    lsu_stall_i = 1'b0;
    int_i       = 1'b0;
    lsu_rdata_i = '0;
    valid       = 1'b0;
    cur         = '0;
    build_table();
    limit = tests.size() + 3 + 20;
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;
    for (int i = 0; i < tests.size(); i++) begin
      @(posedge clk_i);
      instr_i     <= tests[i].instr;
      pc_i        <= tests[i].pc;
      lsu_stall_i <= tests[i].stall;
      int_i       <= tests[i].irq;
      lsu_rdata_i <= tests[i].rdata;
      cur         <= tests[i];
      valid       <= 1'b1;
    end
    @(posedge clk_i);
    valid <= 1'b0;
    @(negedge clk_i);
    $display("tests run %0d, failures %0d", checks, errors);
    if (errors == 0 && checks == tests.size()) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
